// ==== design/dcache_pkg.sv ====
package dcache_pkg;

  ////////////////////////////////////////
  // Geometry

  localparam int NUM_WAYS   = 4;
  localparam int LINE_WORDS = 16;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [21:0] tag_t;     // addr[31:10]
  typedef logic [3:0]  index_t;   // addr[9:6]
  typedef logic [3:0]  offset_t;  // addr[5:2]
  typedef logic [3:0]  byte_en_t;
  typedef logic [1:0]  way_t;
  typedef logic [1:0]  age_t;     // 0 is most recent

  ////////////////////////////////////////
  // Bundles

  typedef struct packed {
    logic     we;
    addr_t    addr;
    word_t    wdata;
    byte_en_t be;
  } cpu_req_t;

  typedef struct packed {
    logic  req;   // Held for the whole burst
    logic  we;
    addr_t addr;  // Line aligned
    word_t wdata;
  } bus_out_t;

  typedef struct packed {
    logic   wb_needed;
    way_t   way;
    index_t index;
    tag_t   victim_tag;
    tag_t   new_tag;
  } fill_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MISS_WAIT,
    FINISH
  } ctrl_state_t;

endpackage

// ==== design/dcache_tag_store.sv ====
`timescale 1ns/1ps

module dcache_tag_store (
  input  logic               clk,
  input  logic               rst,
  input  dcache_pkg::index_t index,
  input  dcache_pkg::tag_t   tag,
  output logic               hit,
  output dcache_pkg::way_t   hit_way,
  output dcache_pkg::way_t   victim_way,
  output logic               victim_dirty,
  output dcache_pkg::tag_t   victim_tag,
  input  logic               touch,
  input  dcache_pkg::way_t   touch_way,
  input  logic               set_dirty,
  input  logic               install,
  input  dcache_pkg::way_t   install_way,
  input  dcache_pkg::index_t install_index,
  input  dcache_pkg::tag_t   install_tag
);

  localparam int SETS = 2 ** $bits(dcache_pkg::index_t);

  dcache_pkg::tag_t tags [dcache_pkg::NUM_WAYS][SETS];
  dcache_pkg::age_t age [dcache_pkg::NUM_WAYS][SETS];
  logic [SETS-1:0] valid [dcache_pkg::NUM_WAYS];
  logic [SETS-1:0] dirty [dcache_pkg::NUM_WAYS];
  logic found_invalid;

  // Tag match across all ways
  always_comb
  begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++)
    begin
      if (valid[w][index] && (tags[w][index] == tag))
      begin
        hit = 1'b1;
        hit_way = dcache_pkg::way_t'(w);
      end
    end
  end

  // Empty way first, else the oldest one
  always_comb
  begin
    found_invalid = 1'b0;
    victim_way = '0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++)
    begin
      if (!found_invalid && !valid[w][index])
      begin
        victim_way = dcache_pkg::way_t'(w);
        found_invalid = 1'b1;
      end
    end
    if (!found_invalid)
    begin
      for (int w = 1; w < dcache_pkg::NUM_WAYS; w++)
      begin
        if (age[w][index] > age[victim_way][index])  // Ties keep the lower way
          victim_way = dcache_pkg::way_t'(w);
      end
    end
  end

  assign victim_dirty = valid[victim_way][index] & dirty[victim_way][index];
  assign victim_tag   = tags[victim_way][index];

  ////////////////////////////////////////
  // State update

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
        for (int s = 0; s < SETS; s++)
          age[w][s] <= '0;
      end
    end
    else
    begin
      if (touch)
      begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++)
        begin
          if (dcache_pkg::way_t'(w) == touch_way)
            age[w][index] <= '0;
          else if (age[w][index] <= age[touch_way][index])
            age[w][index] <= age[w][index] + 1'b1;
        end
      end
      if (set_dirty)
        dirty[touch_way][index] <= 1'b1;
      if (install)
      begin
        valid[install_way][install_index] <= 1'b1;
        dirty[install_way][install_index] <= 1'b0;  // Fresh line matches memory
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (install)
      tags[install_way][install_index] <= install_tag;
  end

endmodule

// ==== design/dcache_data_store.sv ====
`timescale 1ns/1ps

module dcache_data_store (
  input  logic                 clk,
  // CPU port
  input  dcache_pkg::way_t     way_sel,
  input  dcache_pkg::index_t   index,
  input  dcache_pkg::offset_t  offset,
  input  dcache_pkg::byte_en_t word_we,
  input  dcache_pkg::word_t    word_wdata,
  output dcache_pkg::word_t    rd_word,
  // Refill port
  input  logic                 fill_we,
  input  dcache_pkg::way_t     fill_way,
  input  dcache_pkg::index_t   fill_index,
  input  dcache_pkg::offset_t  fill_offset,
  input  dcache_pkg::word_t    fill_word,
  // Write-back read port
  input  dcache_pkg::way_t     wb_way,
  input  dcache_pkg::offset_t  wb_offset,
  output dcache_pkg::word_t    wb_word
);

  localparam int SETS = 2 ** $bits(dcache_pkg::index_t);

  dcache_pkg::word_t mem [dcache_pkg::NUM_WAYS][SETS][dcache_pkg::LINE_WORDS];

  ////////////////////////////////////////
  // Write ports

  always_ff @(posedge clk)
  begin
    for (int b = 0; b < $bits(dcache_pkg::byte_en_t); b++)
    begin
      if (word_we[b])
        mem[way_sel][index][offset][8*b +: 8] <= word_wdata[8*b +: 8];
    end
    if (fill_we)
      mem[fill_way][fill_index][fill_offset] <= fill_word;  // Whole word per beat
  end

  ////////////////////////////////////////
  // Read ports

  assign rd_word = mem[way_sel][index][offset];

  // Victim and new line share a set
  assign wb_word = mem[wb_way][fill_index][wb_offset];

endmodule

// ==== design/dcache_refill_engine.sv ====
`timescale 1ns/1ps

module dcache_refill_engine (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fill_start,
  input  dcache_pkg::fill_cmd_t fill_cmd,
  output logic                  fill_done,
  output dcache_pkg::bus_out_t  bus,
  input  logic                  data_ok,
  input  dcache_pkg::word_t     sdata,
  output dcache_pkg::way_t      wb_way,
  output dcache_pkg::offset_t   wb_offset,
  input  dcache_pkg::word_t     wb_word,
  output logic                  fill_we,
  output dcache_pkg::way_t      fill_way,
  output dcache_pkg::index_t    fill_index,
  output dcache_pkg::offset_t   fill_offset,
  output dcache_pkg::word_t     fill_word,
  output logic                  install,
  output dcache_pkg::way_t      install_way,
  output dcache_pkg::index_t    install_index,
  output dcache_pkg::tag_t      install_tag
);

  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    REFILL
  } eng_state_t;

  eng_state_t state;
  dcache_pkg::fill_cmd_t cmd;
  dcache_pkg::offset_t beat;
  logic last_beat;

  assign last_beat = data_ok && (beat == dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      beat <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (fill_start)
          begin
            beat <= '0;
            state <= fill_cmd.wb_needed ? WRITEBACK : REFILL;
          end
        end
        WRITEBACK:
        begin
          if (data_ok)
            beat <= beat + 1'b1;  // Wraps to 0 for the refill
          if (last_beat)
            state <= REFILL;
        end
        REFILL:
        begin
          if (data_ok)
            beat <= beat + 1'b1;
          if (last_beat)
          begin
            state <= IDLE;
            fill_done <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && fill_start)
      cmd <= fill_cmd;
  end

  ////////////////////////////////////////
  // Bus and store side

  always_comb
  begin
    bus.req = (state != IDLE);
    bus.we = (state == WRITEBACK);
    bus.addr = {(state == WRITEBACK) ? cmd.victim_tag : cmd.new_tag, cmd.index,
                dcache_pkg::offset_t'(0), 2'b00};
    bus.wdata = (state == WRITEBACK) ? wb_word : '0;
  end

  assign wb_way    = cmd.way;
  assign wb_offset = beat;

  assign fill_we     = (state == REFILL) && data_ok;
  assign fill_way    = cmd.way;
  assign fill_index  = cmd.index;
  assign fill_offset = beat;
  assign fill_word   = sdata;

  assign install       = fill_done;  // Tag goes in once the line is whole
  assign install_way   = cmd.way;
  assign install_index = cmd.index;
  assign install_tag   = cmd.new_tag;

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  // CPU side
  input  logic                  req,
  input  dcache_pkg::cpu_req_t  cpu_req,
  output logic                  ok,
  output logic                  miss,
  output dcache_pkg::word_t     rdata,
  // Tag store
  output dcache_pkg::index_t    index,
  output dcache_pkg::tag_t      tag,
  input  logic                  hit,
  input  dcache_pkg::way_t      hit_way,
  input  dcache_pkg::way_t      victim_way,
  input  logic                  victim_dirty,
  input  dcache_pkg::tag_t      victim_tag,
  output logic                  touch,
  output dcache_pkg::way_t      touch_way,
  output logic                  set_dirty,
  // Data store
  output dcache_pkg::byte_en_t  word_we,
  output dcache_pkg::word_t     word_wdata,
  output dcache_pkg::offset_t   offset,
  output dcache_pkg::way_t      way_sel,
  input  dcache_pkg::word_t     rd_word,
  // Refill engine
  output logic                  fill_start,
  output dcache_pkg::fill_cmd_t fill_cmd,
  input  logic                  fill_done
);

  dcache_pkg::ctrl_state_t state;
  dcache_pkg::ctrl_state_t state_nxt;
  dcache_pkg::cpu_req_t req_q;
  logic serve;

  function automatic dcache_pkg::word_t merge_bytes(
    input dcache_pkg::word_t    old_word,
    input dcache_pkg::word_t    new_word,
    input dcache_pkg::byte_en_t be
  );
    dcache_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < $bits(be); b++)
    begin
      if (be[b])
        result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  // Address fields of the held request
  assign tag    = req_q.addr[31:10];
  assign index  = req_q.addr[9:6];
  assign offset = req_q.addr[5:2];

  ////////////////////////////////////////
  // FSM

  always_comb
  begin
    state_nxt = state;
    case (state)
      dcache_pkg::IDLE:      if (req) state_nxt = dcache_pkg::LOOKUP;
      dcache_pkg::LOOKUP:    state_nxt = hit ? dcache_pkg::IDLE : dcache_pkg::MISS_WAIT;
      dcache_pkg::MISS_WAIT: if (fill_done) state_nxt = dcache_pkg::FINISH;
      dcache_pkg::FINISH:    state_nxt = dcache_pkg::IDLE;
      default:               state_nxt = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= dcache_pkg::IDLE;
      ok <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      ok <= serve;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == dcache_pkg::IDLE && req)
      req_q <= cpu_req;
    if (serve)
      rdata <= req_q.we ? merge_bytes(rd_word, req_q.wdata, req_q.be) : rd_word;
  end

  // Line is resident here, either on a hit or after the refill
  assign serve = ((state == dcache_pkg::LOOKUP) && hit) || (state == dcache_pkg::FINISH);

  assign miss = ((state == dcache_pkg::LOOKUP) && !hit) ||
                (state == dcache_pkg::MISS_WAIT) || (state == dcache_pkg::FINISH);

  ////////////////////////////////////////
  // Store and engine controls

  assign touch      = serve;
  assign touch_way  = hit_way;
  assign set_dirty  = serve && req_q.we;
  assign way_sel    = hit_way;
  assign word_we    = (serve && req_q.we) ? req_q.be : '0;
  assign word_wdata = req_q.wdata;

  assign fill_start = (state == dcache_pkg::LOOKUP) && !hit;

  always_comb
  begin
    fill_cmd.wb_needed = victim_dirty;
    fill_cmd.way = victim_way;
    fill_cmd.index = index;
    fill_cmd.victim_tag = victim_tag;
    fill_cmd.new_tag = tag;
  end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req,
  input  dcache_pkg::cpu_req_t cpu_req,
  output logic                 ok,
  output logic                 miss,
  output dcache_pkg::word_t    rdata,
  output dcache_pkg::bus_out_t bus,
  input  logic                 data_ok,
  input  dcache_pkg::word_t    sdata
);

  dcache_pkg::index_t    index;
  dcache_pkg::tag_t      tag;
  logic                  hit;
  dcache_pkg::way_t      hit_way;
  dcache_pkg::way_t      victim_way;
  logic                  victim_dirty;
  dcache_pkg::tag_t      victim_tag;
  logic                  touch;
  dcache_pkg::way_t      touch_way;
  logic                  set_dirty;
  dcache_pkg::byte_en_t  word_we;
  dcache_pkg::word_t     word_wdata;
  dcache_pkg::offset_t   offset;
  dcache_pkg::way_t      way_sel;
  dcache_pkg::word_t     rd_word;
  logic                  fill_start;
  dcache_pkg::fill_cmd_t fill_cmd;
  logic                  fill_done;
  dcache_pkg::way_t      wb_way;
  dcache_pkg::offset_t   wb_offset;
  dcache_pkg::word_t     wb_word;
  logic                  fill_we;
  dcache_pkg::way_t      fill_way;
  dcache_pkg::index_t    fill_index;
  dcache_pkg::offset_t   fill_offset;
  dcache_pkg::word_t     fill_word;
  logic                  install;
  dcache_pkg::way_t      install_way;
  dcache_pkg::index_t    install_index;
  dcache_pkg::tag_t      install_tag;

  dcache_ctrl i_ctrl (
    .clk, .rst, .req, .cpu_req, .ok, .miss, .rdata,
    .index, .tag, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .touch, .touch_way, .set_dirty,
    .word_we, .word_wdata, .offset, .way_sel, .rd_word,
    .fill_start, .fill_cmd, .fill_done
  );

  dcache_tag_store i_tag_store (
    .clk, .rst, .index, .tag, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .touch, .touch_way, .set_dirty,
    .install, .install_way, .install_index, .install_tag
  );

  dcache_data_store i_data_store (
    .clk, .way_sel, .index, .offset, .word_we, .word_wdata, .rd_word,
    .fill_we, .fill_way, .fill_index, .fill_offset, .fill_word,
    .wb_way, .wb_offset, .wb_word
  );

  dcache_refill_engine i_refill_engine (
    .clk, .rst, .fill_start, .fill_cmd, .fill_done, .bus, .data_ok, .sdata,
    .wb_way, .wb_offset, .wb_word,
    .fill_we, .fill_way, .fill_index, .fill_offset, .fill_word,
    .install, .install_way, .install_index, .install_tag
  );

endmodule

// ==== verif/dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 ok,
  input logic                 miss,
  input dcache_pkg::bus_out_t bus
);

  ok_single: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("ok stayed high for more than one cycle");

  // Bus traffic only while the request waits on a miss
  burst_in_miss: assert property (@(posedge clk) disable iff (rst) bus.req |-> miss)
    else $error("bus burst running while miss was low");

  no_ok_during_burst: assert property (@(posedge clk) disable iff (rst) bus.req |-> !ok)
    else $error("ok pulsed while a bus burst was running");

  miss_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !miss)
    else $error("miss was high right after reset");

endmodule

bind dcache_top dcache_props i_props (
  .clk(clk),
  .rst(rst),
  .ok(ok),
  .miss(miss),
  .bus(bus)
);

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

  localparam int NUM_REQS  = 330;
  localparam int MEM_WORDS = 16384;  // 64 KB of bus memory
  localparam int SETS      = 16;
  localparam int WAYS      = dcache_pkg::NUM_WAYS;
  localparam int WORDS     = dcache_pkg::LINE_WORDS;

  logic clk;
  logic rst;
  logic req;
  dcache_pkg::cpu_req_t cpu_req;
  logic ok;
  logic miss;
  dcache_pkg::word_t rdata;
  dcache_pkg::bus_out_t bus;
  logic data_ok;
  dcache_pkg::word_t sdata;

  dcache_pkg::word_t mem [MEM_WORDS];     // Bus side
  dcache_pkg::word_t shadow [MEM_WORDS];  // Memory as the reference model sees it

  // Reference cache state
  logic ref_valid [WAYS][SETS];
  logic ref_dirty [WAYS][SETS];
  dcache_pkg::tag_t ref_tag [WAYS][SETS];
  dcache_pkg::age_t ref_age [WAYS][SETS];
  dcache_pkg::word_t ref_line [WAYS][SETS][WORDS];

  dcache_pkg::word_t exp_rdata [$];
  dcache_pkg::addr_t exp_burst_addr [$];
  logic exp_burst_we [$];
  dcache_pkg::word_t exp_wb_data [$];

  logic [31:0] bus_seed;
  logic [31:0] stim_seed;
  int errors;
  int tests;
  int wb_bursts;
  int beat;
  dcache_pkg::addr_t burst_addr;
  dcache_pkg::word_t exp_word;

  dcache_top i_dcache_top (
    .clk, .rst, .req, .cpu_req, .ok, .miss, .rdata, .bus, .data_ok, .sdata
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic dcache_pkg::word_t mem_pattern(input int i);
    logic [31:0] a;
    a = i;
    return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic dcache_pkg::word_t byte_merge(input dcache_pkg::word_t old_word,
                                                   input dcache_pkg::word_t new_word,
                                                   input dcache_pkg::byte_en_t be);
    dcache_pkg::word_t w;
    w = old_word;
    for (int b = 0; b < 4; b++)
    begin
      if (be[b])
        w[8*b +: 8] = new_word[8*b +: 8];
    end
    return w;
  endfunction

  function automatic dcache_pkg::way_t pick_victim(input dcache_pkg::index_t idx);
    dcache_pkg::way_t best;
    for (int w = 0; w < WAYS; w++)
    begin
      if (!ref_valid[w][idx])
        return dcache_pkg::way_t'(w);
    end
    best = '0;
    for (int w = 1; w < WAYS; w++)
    begin
      if (ref_age[w][idx] > ref_age[best][idx])  // strictly older only
        best = dcache_pkg::way_t'(w);
    end
    return best;
  endfunction

  function automatic void update_lru(input dcache_pkg::index_t idx, input dcache_pkg::way_t way);
    dcache_pkg::age_t old_age;
    old_age = ref_age[way][idx];
    for (int w = 0; w < WAYS; w++)
    begin
      if (w == way)
        ref_age[w][idx] = '0;
      else if (ref_age[w][idx] <= old_age)
        ref_age[w][idx] = ref_age[w][idx] + 1'b1;
    end
  endfunction

  // Expected rdata of one request; also queues the bursts it should cause
  function automatic dcache_pkg::word_t model_access(input dcache_pkg::cpu_req_t r,
                                                     output logic was_hit);
    dcache_pkg::tag_t t;
    dcache_pkg::index_t idx;
    dcache_pkg::offset_t off;
    dcache_pkg::way_t way;
    dcache_pkg::addr_t base;
    t = r.addr[31:10];
    idx = r.addr[9:6];
    off = r.addr[5:2];
    was_hit = 1'b0;
    way = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (ref_valid[w][idx] && (ref_tag[w][idx] == t))
      begin
        was_hit = 1'b1;
        way = dcache_pkg::way_t'(w);
      end
    end
    if (!was_hit)
    begin
      way = pick_victim(idx);
      if (ref_valid[way][idx] && ref_dirty[way][idx])
      begin
        base = {ref_tag[way][idx], idx, 6'd0};
        exp_burst_addr.push_back(base);
        exp_burst_we.push_back(1'b1);
        for (int i = 0; i < WORDS; i++)
        begin
          exp_wb_data.push_back(ref_line[way][idx][i]);
          shadow[base[15:2] + i] = ref_line[way][idx][i];
        end
      end
      base = {t, idx, 6'd0};
      exp_burst_addr.push_back(base);
      exp_burst_we.push_back(1'b0);
      for (int i = 0; i < WORDS; i++)
        ref_line[way][idx][i] = shadow[base[15:2] + i];
      ref_valid[way][idx] = 1'b1;
      ref_tag[way][idx] = t;
      ref_dirty[way][idx] = 1'b0;
    end
    update_lru(idx, way);
    if (r.we)
    begin
      ref_line[way][idx][off] = byte_merge(ref_line[way][idx][off], r.wdata, r.be);
      ref_dirty[way][idx] = 1'b1;
    end
    return ref_line[way][idx][off];
  endfunction

  ////////////////////////////////////////
  // Bus memory model

  always @(posedge clk)
  begin
    if (bus.req && data_ok)
    begin
      if (beat == 0)
      begin
        burst_addr = bus.addr;
        assert (exp_burst_addr.size() > 0)
        else
        begin
          $display("Error at %0d ns: bus burst at %h that the model did not expect",
                   $time, bus.addr);
          errors++;
        end
        if (exp_burst_addr.size() > 0)
        begin
          assert ((bus.addr == exp_burst_addr[0]) && (bus.we == exp_burst_we[0]))
          else
          begin
            $display("Mismatch at %0d ns: burst addr %h we %b, expected addr %h we %b",
                     $time, bus.addr, bus.we, exp_burst_addr[0], exp_burst_we[0]);
            errors++;
          end
          void'(exp_burst_addr.pop_front());
          void'(exp_burst_we.pop_front());
        end
        if (bus.we)
          wb_bursts++;
      end
      assert (bus.addr == burst_addr)
      else
      begin
        $display("Mismatch at %0d ns: bus addr %h changed within burst at %h",
                 $time, bus.addr, burst_addr);
        errors++;
      end
      if (bus.we)
      begin
        mem[bus.addr[15:2] + beat] = bus.wdata;
        if (exp_wb_data.size() > 0)
        begin
          assert (bus.wdata == exp_wb_data[0])
          else
          begin
            $display("Mismatch at %0d ns: write beat %0d data %h, expected %h",
                     $time, beat, bus.wdata, exp_wb_data[0]);
            errors++;
          end
          void'(exp_wb_data.pop_front());
        end
      end
      beat = (beat + 1) % WORDS;
    end
    else if (!bus.req)
    begin
      assert (beat == 0)
      else
      begin
        $display("Error at %0d ns: bus burst ended after %0d beats", $time, beat);
        errors++;
      end
      beat = 0;
    end
    #1;
    if (bus.req)
    begin
      bus_seed = lcg(bus_seed);
      data_ok = (bus_seed[31:30] != 2'b00);  // Three beats in four
      sdata = mem[bus.addr[15:2] + beat];
    end
    else
      data_ok = 1'b0;
  end

  ////////////////////////////////////////
  // Response check

  always @(posedge clk)
  begin
    if (!rst && ok)
    begin
      if (exp_rdata.size() == 0)
      begin
        $display("Error at %0d ns: ok pulse with no request outstanding", $time);
        errors++;
      end
      else
      begin
        exp_word = exp_rdata.pop_front();
        assert (rdata == exp_word)
        else
        begin
          $display("Mismatch at %0d ns: rdata %h, expected %h", $time, rdata, exp_word);
          errors++;
        end
      end
    end
  end

  // Starts and ends 1 ns after a rising edge
  task automatic access(input logic we, input dcache_pkg::addr_t addr,
                        input dcache_pkg::word_t wdata, input dcache_pkg::byte_en_t be);
    dcache_pkg::cpu_req_t r;
    logic was_hit;
    logic saw_miss;
    int cycles;
    r.we = we;
    r.addr = addr;
    r.wdata = wdata;
    r.be = be;
    exp_rdata.push_back(model_access(r, was_hit));
    saw_miss = 1'b0;
    cycles = 0;
    req = 1'b1;
    cpu_req = r;
    do
    begin
      @(posedge clk);
      #1;
      req = 1'b0;
      cycles++;
      if (miss)
        saw_miss = 1'b1;
    end
    while (!ok);
    if (was_hit)
    begin
      assert ((cycles == 2) && !saw_miss)
      else
      begin
        $display("Mismatch at %0d ns: hit at %h took %0d cycles, miss seen %b",
                 $time, addr, cycles, saw_miss);
        errors++;
      end
    end
    else
    begin
      assert (saw_miss)
      else
      begin
        $display("Mismatch at %0d ns: access at %h should miss", $time, addr);
        errors++;
      end
    end
    assert (exp_burst_addr.size() == 0)
    else
    begin
      $display("Error at %0d ns: request at %h finished with bursts missing", $time, addr);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  ////////////////////////////////////////
  // Stimulus

  initial
  begin
    int e0;
    int w0;
    int t;
    rst = 1'b1;
    req = 1'b0;
    cpu_req = '0;
    data_ok = 1'b0;
    sdata = '0;
    errors = 0;
    tests = 0;
    wb_bursts = 0;
    beat = 0;
    burst_addr = '0;
    bus_seed = 32'd31;
    stim_seed = 32'd31;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = mem_pattern(i);
      shadow[i] = mem[i];
    end
    for (int w = 0; w < WAYS; w++)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        ref_valid[w][s] = 1'b0;
        ref_dirty[w][s] = 1'b0;
        ref_age[w][s] = '0;
      end
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    e0 = errors;
    access(1'b0, 32'h104, '0, '0);  // cold miss
    access(1'b0, 32'h104, '0, '0);
    report_test("cold read then hit", e0);

    e0 = errors;
    access(1'b1, 32'h104, 32'hAABBCCDD, 4'b0101);
    access(1'b0, 32'h104, '0, '0);
    report_test("write hit byte merge", e0);

    e0 = errors;
    access(1'b1, 32'h2208, 32'h11223344, 4'b0011);
    access(1'b0, 32'h2208, '0, '0);
    report_test("write miss allocate", e0);

    e0 = errors;
    for (t = 1; t <= 4; t++)
      access(1'b0, 32'(t * 1024 + 7 * 64), '0, '0);
    access(1'b0, 32'(2 * 1024 + 7 * 64), '0, '0);
    access(1'b0, 32'(1 * 1024 + 7 * 64), '0, '0);
    access(1'b0, 32'(5 * 1024 + 7 * 64), '0, '0);  // evicts the LRU way
    access(1'b0, 32'(3 * 1024 + 7 * 64), '0, '0);
    report_test("LRU replacement", e0);

    e0 = errors;
    w0 = wb_bursts;
    for (t = 1; t <= 4; t++)
      access(1'b1, 32'(t * 1024 + 9 * 64 + 8), 32'(t * 32'h01010101), 4'b1111);
    access(1'b0, 32'(5 * 1024 + 9 * 64), '0, '0);
    assert (wb_bursts == w0 + 1)
    else
    begin
      $display("Error at %0d ns: dirty eviction gave %0d write bursts", $time, wb_bursts - w0);
      errors++;
    end
    w0 = wb_bursts;
    for (t = 1; t <= 5; t++)
      access(1'b0, 32'(t * 1024 + 10 * 64), '0, '0);
    assert (wb_bursts == w0)
    else
    begin
      $display("Error at %0d ns: clean eviction gave a write burst", $time);
      errors++;
    end
    report_test("dirty and clean eviction", e0);

    e0 = errors;
    for (int i = 0; i < 300; i++)
    begin
      stim_seed = lcg(stim_seed);
      t = stim_seed[30:28] % 6;
      access(stim_seed[31],
             32'(t * 1024) | 32'(stim_seed[27] * 64) | 32'(stim_seed[26:23] * 4),
             lcg(stim_seed), stim_seed[22:19]);
    end
    report_test("random traffic", e0);

    // Last ok reaches the response check on the next edge
    @(posedge clk);
    #1;
    assert (exp_rdata.size() == 0)
    else
    begin
      $display("Error at %0d ns: %0d responses never arrived", $time, exp_rdata.size());
      errors++;
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #((16 + NUM_REQS * 64 + 40 * 16) * 10);
    $display("Timeout: the run did not finish within the time limit");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== src.f ====
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_refill_engine.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv
